//--- hdl/drive_geometry_pkg.sv
package drive_geometry_pkg;

    // Channel 0 is odd, channel 1 is even
    localparam int NUM_CHANNELS = 2;

    // One page of bubble positions
    localparam int PAGE_POSITIONS = 1920;
    localparam int POS_WIDTH = 11;

    // Page counter wraps from 4095 to 0
    localparam int PAGE_WIDTH = 12;

    // Image select DIP switch
    localparam int IMAGE_WIDTH = 3;

    // Flash address of a page start
    localparam int PAGE_ADDR_WIDTH = 22;

    // Zero bits under the page field, one page is 128 bytes
    localparam int PAGE_OFFSET_WIDTH = PAGE_ADDR_WIDTH - IMAGE_WIDTH - PAGE_WIDTH;

endpackage

//--- hdl/drive_timing_pkg.sv
package drive_timing_pkg;

    typedef enum logic [1:0]
    {
        st_idle,
        st_access,
        st_shift,
        st_done
    } seq_state_t;

    // Flops in each host strobe synchroniser
    localparam int SYNC_STAGES = 2;

    // Delay from a detected shift request to the first read strobe
    localparam int ACCESS_CYCLES = 8;

    // Clock cycles per bit position
    localparam int BIT_CYCLES = 4;

    // Counter covers both the access delay and the bit period
    localparam int CYCLE_CNT_WIDTH =
        $clog2((ACCESS_CYCLES > BIT_CYCLES) ? ACCESS_CYCLES : BIT_CYCLES);

endpackage

//--- hdl/shift_sequencer.sv
`timescale 1ns/10ps

module shift_sequencer
    import drive_geometry_pkg::*;
    import drive_timing_pkg::*;
(
    input  logic                       master_clock,
    input  logic                       rst,
    input  logic                       power_good,
    input  logic                       bubble_shift_enable,
    input  logic                       replicator_enable,
    input  logic                       bootloop_enable,
    input  logic [IMAGE_WIDTH-1:0]     image_dip_switch,
    output logic [POS_WIDTH-1:0]       read_address,
    output logic                       read_strobe,
    output logic                       bit_window,
    output logic                       load_page,
    output logic                       load_bootloader,
    output logic [PAGE_ADDR_WIDTH-1:0] start_of_page_address
);

    // Bit 0 shift, bit 1 replicator, bit 2 bootloop
    logic [2:0]                 sync_q [SYNC_STAGES];
    logic [2:0]                 strobe_sync;
    logic [1:0]                 strobe_prev;

    logic                       shift_req;
    logic                       repl_req;
    logic                       shift_released;
    logic                       bootloop;

    seq_state_t                 state;
    logic [CYCLE_CNT_WIDTH-1:0] cycle_cnt;
    logic [PAGE_WIDTH-1:0]      page_cnt;
    logic                       last_position;

    assign strobe_sync = sync_q[SYNC_STAGES-1];

    // Strobes are active low, a request is a falling edge
    assign shift_req      = strobe_prev[0] & ~strobe_sync[0];
    assign repl_req       = strobe_prev[1] & ~strobe_sync[1];
    assign shift_released = strobe_sync[0];
    assign bootloop       = strobe_sync[2];

    assign last_position = (read_address == POS_WIDTH'(PAGE_POSITIONS - 1));

    // Synchronisers keep running while power is low, so held levels
    // do not look like fresh edges when power returns
    always_ff @(posedge master_clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= 3'b011;
            end
            strobe_prev <= 2'b11;
        end
        else
        begin
            sync_q[0] <= {bootloop_enable, replicator_enable, bubble_shift_enable};
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
            strobe_prev <= strobe_sync[1:0];
        end
    end

    always_ff @(posedge master_clock)
    begin
        if (rst || !power_good)
        begin
            state        <= st_idle;
            cycle_cnt    <= '0;
            read_address <= '0;
            read_strobe  <= 1'b0;
            bit_window   <= 1'b0;
        end
        else
        begin
            read_strobe <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (shift_req)
                    begin
                        state     <= st_access;
                        cycle_cnt <= CYCLE_CNT_WIDTH'(ACCESS_CYCLES - 1);
                    end
                end
                st_access:
                begin
                    if (shift_released)
                    begin
                        state <= st_idle;
                    end
                    else if (cycle_cnt == '0)
                    begin
                        state        <= st_shift;
                        read_address <= '0;
                        read_strobe  <= 1'b1;
                        bit_window   <= 1'b1;
                        cycle_cnt    <= CYCLE_CNT_WIDTH'(BIT_CYCLES - 1);
                    end
                    else
                    begin
                        cycle_cnt <= cycle_cnt - 1'b1;
                    end
                end
                st_shift:
                begin
                    if (shift_released)
                    begin
                        // Host gave up mid page
                        state      <= st_idle;
                        bit_window <= 1'b0;
                    end
                    else if (cycle_cnt == '0)
                    begin
                        if (last_position)
                        begin
                            state      <= st_done;
                            bit_window <= 1'b0;
                        end
                        else
                        begin
                            read_address <= read_address + 1'b1;
                            read_strobe  <= 1'b1;
                            cycle_cnt    <= CYCLE_CNT_WIDTH'(BIT_CYCLES - 1);
                        end
                    end
                    else
                    begin
                        cycle_cnt <= cycle_cnt - 1'b1;
                    end
                end
                st_done:
                begin
                    if (shift_released)
                    begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // Page stepping, only between shifts
    always_ff @(posedge master_clock)
    begin
        if (rst || !power_good)
        begin
            page_cnt        <= '0;
            load_page       <= 1'b0;
            load_bootloader <= 1'b0;
        end
        else
        begin
            load_page       <= 1'b0;
            load_bootloader <= 1'b0;
            if (repl_req && (state == st_idle || state == st_done))
            begin
                if (bootloop)
                begin
                    page_cnt        <= '0;
                    load_bootloader <= 1'b1;
                end
                else
                begin
                    page_cnt  <= page_cnt + 1'b1;
                    load_page <= 1'b1;
                end
            end
        end
    end

    // Image in the top bits, page below, 128 byte aligned
    always_ff @(posedge master_clock)
    begin
        start_of_page_address <= {image_dip_switch, page_cnt, {PAGE_OFFSET_WIDTH{1'b0}}};
    end

endmodule

//--- hdl/channel_buffer.sv
`timescale 1ns/10ps

module channel_buffer
    import drive_geometry_pkg::*;
(
    input  logic                 master_clock,
    input  logic                 rst,
    input  logic                 write_enable,
    input  logic                 write_strobe,
    input  logic [POS_WIDTH-1:0] write_address,
    input  logic                 write_bit,
    input  logic                 read_strobe,
    input  logic [POS_WIDTH-1:0] read_address,
    output logic                 channel_bit
);

    logic page_mem [PAGE_POSITIONS];
    logic write_hit;

    // Write enable is active low, addresses past the page are dropped
    assign write_hit = write_strobe && !write_enable &&
                       (write_address < POS_WIDTH'(PAGE_POSITIONS));

    always_ff @(posedge master_clock)
    begin
        if (write_hit)
        begin
            page_mem[write_address] <= write_bit;
        end
    end

    // Bit holds for the whole position
    always_ff @(posedge master_clock)
    begin
        if (rst)
        begin
            channel_bit <= 1'b0;
        end
        else if (read_strobe)
        begin
            channel_bit <= page_mem[read_address];
        end
    end

endmodule

//--- hdl/bubble_output_stage.sv
`timescale 1ns/10ps

module bubble_output_stage
    import drive_geometry_pkg::*;
(
    input  logic                    master_clock,
    input  logic                    rst,
    input  logic                    bit_window,
    input  logic [NUM_CHANNELS-1:0] channel_bits,
    output logic                    bubble_out_odd,
    output logic                    bubble_out_even
);

    logic                    window_d;
    logic [NUM_CHANNELS-1:0] gated_bits;
    logic [NUM_CHANNELS-1:0] out_q;

    // Buffer read costs one cycle
    always_ff @(posedge master_clock)
    begin
        if (rst)
        begin
            window_d <= 1'b0;
        end
        else
        begin
            window_d <= bit_window;
        end
    end

    // Line stays at 0 outside the window
    assign gated_bits = channel_bits & {NUM_CHANNELS{window_d}};

    always_ff @(posedge master_clock)
    begin
        if (rst)
        begin
            out_q <= '0;
        end
        else
        begin
            out_q <= gated_bits;
        end
    end

    assign bubble_out_odd  = out_q[0];
    assign bubble_out_even = out_q[1];

endmodule

//--- hdl/bubble_drive_top.sv
`timescale 1ns/10ps

module bubble_drive_top
    import drive_geometry_pkg::*;
(
    input  logic                       master_clock,
    input  logic                       rst,

    input  logic                       power_good,
    input  logic                       bubble_shift_enable,
    input  logic                       replicator_enable,
    input  logic                       bootloop_enable,
    input  logic [IMAGE_WIDTH-1:0]     image_dip_switch,

    input  logic                       bubble_buffer_write_enable,
    input  logic                       bubble_buffer_write_strobe,
    input  logic [POS_WIDTH-1:0]       bubble_buffer_write_address,
    input  logic [NUM_CHANNELS-1:0]    bubble_buffer_data_input,

    output logic                       bubble_out_odd,
    output logic                       bubble_out_even,
    output logic                       load_page,
    output logic                       load_bootloader,
    output logic [PAGE_ADDR_WIDTH-1:0] start_of_page_address
);

    logic [POS_WIDTH-1:0]    read_address;
    logic                    read_strobe;
    logic                    bit_window;
    logic [NUM_CHANNELS-1:0] channel_bits;

    shift_sequencer sequencer_i
    (
        .master_clock          (master_clock),
        .rst                   (rst),
        .power_good            (power_good),
        .bubble_shift_enable   (bubble_shift_enable),
        .replicator_enable     (replicator_enable),
        .bootloop_enable       (bootloop_enable),
        .image_dip_switch      (image_dip_switch),
        .read_address          (read_address),
        .read_strobe           (read_strobe),
        .bit_window            (bit_window),
        .load_page             (load_page),
        .load_bootloader       (load_bootloader),
        .start_of_page_address (start_of_page_address)
    );

    // Data bit i belongs to channel i
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++)
    begin : g_channel
        channel_buffer buffer_i
        (
            .master_clock  (master_clock),
            .rst           (rst),
            .write_enable  (bubble_buffer_write_enable),
            .write_strobe  (bubble_buffer_write_strobe),
            .write_address (bubble_buffer_write_address),
            .write_bit     (bubble_buffer_data_input[ch]),
            .read_strobe   (read_strobe),
            .read_address  (read_address),
            .channel_bit   (channel_bits[ch])
        );
    end

    bubble_output_stage output_stage_i
    (
        .master_clock    (master_clock),
        .rst             (rst),
        .bit_window      (bit_window),
        .channel_bits    (channel_bits),
        .bubble_out_odd  (bubble_out_odd),
        .bubble_out_even (bubble_out_even)
    );

endmodule

//--- testbench/bubble_drive_tb.sv
`timescale 1ns/10ps

module bubble_drive_tb
    import drive_geometry_pkg::*;
    import drive_timing_pkg::*;
();

    localparam logic [IMAGE_WIDTH-1:0] DIP_SETTING = 3'b101;

    // Synchroniser plus the edge detect register
    localparam int REQ_DETECT_CYCLES = SYNC_STAGES + 1;
    // Buffer read and output register follow the access delay
    localparam int FIRST_BIT_CYCLES = REQ_DETECT_CYCLES + ACCESS_CYCLES + 2;
    localparam int STREAM_CYCLES = PAGE_POSITIONS * BIT_CYCLES;
    localparam int ABORT_SETTLE_CYCLES = REQ_DETECT_CYCLES + 2;
    localparam int SHIFT_CYCLES = FIRST_BIT_CYCLES + STREAM_CYCLES;
    // Margin covers page loading and the replicator sweep past the wrap
    localparam int WATCHDOG_CYCLES =
        4 * SHIFT_CYCLES + 2 * PAGE_POSITIONS + 4 * (2 ** PAGE_WIDTH) + 1000;

    logic                       master_clock = 1'b0;
    logic                       rst;
    logic                       power_good;
    logic                       bubble_shift_enable;
    logic                       replicator_enable;
    logic                       bootloop_enable;
    logic [IMAGE_WIDTH-1:0]     image_dip_switch;
    logic                       bubble_buffer_write_enable;
    logic                       bubble_buffer_write_strobe;
    logic [POS_WIDTH-1:0]       bubble_buffer_write_address;
    logic [NUM_CHANNELS-1:0]    bubble_buffer_data_input;
    logic                       bubble_out_odd;
    logic                       bubble_out_even;
    logic                       load_page;
    logic                       load_bootloader;
    logic [PAGE_ADDR_WIDTH-1:0] start_of_page_address;

    // Reference model state
    logic [NUM_CHANNELS-1:0]    page_mirror [PAGE_POSITIONS];
    logic [31:0]                lcg_state;
    int                         cyc = 0;
    logic                       checks_on;
    logic                       shift_on;
    int                         shift_fall;
    logic                       abort_on;
    int                         abort_at;
    logic [1:0]                 load_kind;
    int                         load_at;
    logic [PAGE_WIDTH-1:0]      page_prev;
    logic [PAGE_WIDTH-1:0]      page_ref;
    int                         page_switch;
    int                         mismatch_count;
    int                         failure_count;

    // Expected values for the current cycle
    int                         stream_pos;
    int                         position;
    logic                       after_abort;
    logic                       in_stream;
    logic                       out_checked;
    logic                       exp_odd;
    logic                       exp_even;
    logic                       exp_load_page;
    logic                       exp_load_boot;
    logic [PAGE_WIDTH-1:0]      exp_page;
    logic [PAGE_ADDR_WIDTH-1:0] exp_address;

    bubble_drive_top dut_i
    (
        .master_clock                (master_clock),
        .rst                         (rst),
        .power_good                  (power_good),
        .bubble_shift_enable         (bubble_shift_enable),
        .replicator_enable           (replicator_enable),
        .bootloop_enable             (bootloop_enable),
        .image_dip_switch            (image_dip_switch),
        .bubble_buffer_write_enable  (bubble_buffer_write_enable),
        .bubble_buffer_write_strobe  (bubble_buffer_write_strobe),
        .bubble_buffer_write_address (bubble_buffer_write_address),
        .bubble_buffer_data_input    (bubble_buffer_data_input),
        .bubble_out_odd              (bubble_out_odd),
        .bubble_out_even             (bubble_out_even),
        .load_page                   (load_page),
        .load_bootloader             (load_bootloader),
        .start_of_page_address       (start_of_page_address)
    );

    always #50 master_clock = ~master_clock;

    always @(posedge master_clock)
    begin
        cyc <= cyc + 1;
    end

    always_comb
    begin
        stream_pos  = cyc - shift_fall - FIRST_BIT_CYCLES;
        after_abort = abort_on && (cyc >= abort_at);
        in_stream   = shift_on && !after_abort && (stream_pos >= 0) &&
                      (stream_pos < STREAM_CYCLES);
        position    = in_stream ? stream_pos / BIT_CYCLES : 0;
        out_checked = 1'b1;
        exp_odd     = 1'b0;
        exp_even    = 1'b0;
        if (in_stream)
        begin
            // Sample in the middle of the bit period
            out_checked = (stream_pos % BIT_CYCLES) == (BIT_CYCLES / 2);
            exp_odd     = page_mirror[position][0];
            exp_even    = page_mirror[position][1];
        end
        else if (after_abort && (cyc < abort_at + ABORT_SETTLE_CYCLES))
        begin
            out_checked = 1'b0;
        end
        exp_load_page = (load_kind == 2'd1) && (cyc == load_at);
        exp_load_boot = (load_kind == 2'd2) && (cyc == load_at);
        exp_page      = (cyc < page_switch) ? page_prev : page_ref;
        exp_address   = {DIP_SETTING, exp_page, {PAGE_OFFSET_WIDTH{1'b0}}};
    end

    task automatic record_mismatch(input string name, input logic [31:0] expected_value,
                                   input logic [31:0] actual_value);
        mismatch_count++;
        $display("Mismatch at %0t ns: %s expected %0h actual %0h",
                 $time, name, expected_value, actual_value);
    endtask

    task automatic note_failure(input string what);
        failure_count++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    endtask

    odd_check: assert property (@(posedge master_clock) disable iff (!checks_on)
        !out_checked || (bubble_out_odd == exp_odd))
    else
        record_mismatch("bubble_out_odd", 32'($sampled(exp_odd)),
                        32'($sampled(bubble_out_odd)));

    even_check: assert property (@(posedge master_clock) disable iff (!checks_on)
        !out_checked || (bubble_out_even == exp_even))
    else
        record_mismatch("bubble_out_even", 32'($sampled(exp_even)),
                        32'($sampled(bubble_out_even)));

    load_page_check: assert property (@(posedge master_clock) disable iff (!checks_on)
        load_page == exp_load_page)
    else
        record_mismatch("load_page", 32'($sampled(exp_load_page)),
                        32'($sampled(load_page)));

    load_boot_check: assert property (@(posedge master_clock) disable iff (!checks_on)
        load_bootloader == exp_load_boot)
    else
        record_mismatch("load_bootloader", 32'($sampled(exp_load_boot)),
                        32'($sampled(load_bootloader)));

    address_check: assert property (@(posedge master_clock) disable iff (!checks_on)
        start_of_page_address == exp_address)
    else
        record_mismatch("start_of_page_address", 32'($sampled(exp_address)),
                        32'($sampled(start_of_page_address)));

    known_check: assert property (@(posedge master_clock) disable iff (!checks_on)
        !$isunknown({bubble_out_odd, bubble_out_even, load_page, load_bootloader}))
    else
        note_failure("DUT outputs went unknown after reset");

    function automatic logic [31:0] lcg_next(input logic [31:0] seed_value);
        return seed_value * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic write_position(input logic [POS_WIDTH-1:0] addr,
                                  input logic [NUM_CHANNELS-1:0] data,
                                  input logic enable_n);
        @(posedge master_clock);
        bubble_buffer_write_enable  <= enable_n;
        bubble_buffer_write_strobe  <= 1'b1;
        bubble_buffer_write_address <= addr;
        bubble_buffer_data_input    <= data;
        @(posedge master_clock);
        bubble_buffer_write_strobe  <= 1'b0;
        bubble_buffer_write_enable  <= 1'b1;
        if (!enable_n)
        begin
            page_mirror[addr] = data;
        end
    endtask

    task automatic load_page_image();
        for (int pos = 0; pos < PAGE_POSITIONS; pos++)
        begin
            lcg_state = lcg_next(lcg_state);
            write_position(POS_WIDTH'(pos), lcg_state[17:16], 1'b0);
        end
    endtask

    // Disabled writes try to invert the stored bits
    task automatic scatter_writes(input int count, input logic enable_n);
        logic [POS_WIDTH-1:0]    addr;
        logic [NUM_CHANNELS-1:0] data;
        for (int i = 0; i < count; i++)
        begin
            lcg_state = lcg_next(lcg_state);
            addr = POS_WIDTH'(lcg_state[26:16] % PAGE_POSITIONS);
            data = enable_n ? ~page_mirror[addr] : lcg_state[29:28];
            write_position(addr, data, enable_n);
        end
    endtask

    task automatic start_shift();
        @(posedge master_clock);
        bubble_shift_enable <= 1'b0;
        shift_on            <= 1'b1;
        shift_fall          <= cyc + 1;
        abort_on            <= 1'b0;
    endtask

    task automatic run_full_shift();
        start_shift();
        repeat (SHIFT_CYCLES + 4) @(posedge master_clock);
        bubble_shift_enable <= 1'b1;
        repeat (2 * REQ_DETECT_CYCLES) @(posedge master_clock);
    endtask

    task automatic abort_mid_page(input int positions);
        start_shift();
        repeat (FIRST_BIT_CYCLES + positions * BIT_CYCLES + 1) @(posedge master_clock);
        bubble_shift_enable <= 1'b1;
        abort_on            <= 1'b1;
        abort_at            <= cyc + 1;
        repeat (4 * ABORT_SETTLE_CYCLES) @(posedge master_clock);
    endtask

    task automatic pulse_replicator(input logic powered, input logic boot);
        @(posedge master_clock);
        replicator_enable <= 1'b0;
        if (powered)
        begin
            load_kind   <= boot ? 2'd2 : 2'd1;
            load_at     <= cyc + 1 + REQ_DETECT_CYCLES;
            page_prev   <= page_ref;
            page_ref    <= boot ? '0 : page_ref + PAGE_WIDTH'(1);
            page_switch <= cyc + 2 + REQ_DETECT_CYCLES;
        end
        @(posedge master_clock);
        @(posedge master_clock);
        replicator_enable <= 1'b1;
        @(posedge master_clock);
    endtask

    // Sequencer is held in reset, so the page counter clears
    task automatic power_loss_check();
        @(posedge master_clock);
        power_good  <= 1'b0;
        shift_on    <= 1'b0;
        page_prev   <= page_ref;
        page_ref    <= '0;
        page_switch <= cyc + 3;
        repeat (4) @(posedge master_clock);
        bubble_shift_enable <= 1'b0;
        repeat (FIRST_BIT_CYCLES + 8 * BIT_CYCLES) @(posedge master_clock);
        pulse_replicator(1'b0, 1'b0);
        repeat (8) @(posedge master_clock);
        bubble_shift_enable <= 1'b1;
        repeat (2 * REQ_DETECT_CYCLES) @(posedge master_clock);
        power_good <= 1'b1;
        repeat (FIRST_BIT_CYCLES + 8 * BIT_CYCLES) @(posedge master_clock);
    endtask

    initial
    begin
        rst                         = 1'b1;
        power_good                  = 1'b1;
        bubble_shift_enable         = 1'b1;
        replicator_enable           = 1'b1;
        bootloop_enable             = 1'b0;
        image_dip_switch            = DIP_SETTING;
        bubble_buffer_write_enable  = 1'b1;
        bubble_buffer_write_strobe  = 1'b0;
        bubble_buffer_write_address = '0;
        bubble_buffer_data_input    = '0;
        lcg_state                   = 32'ha9e9;
        checks_on                   = 1'b0;
        shift_on                    = 1'b0;
        shift_fall                  = 0;
        abort_on                    = 1'b0;
        abort_at                    = 0;
        load_kind                   = 2'd0;
        load_at                     = 0;
        page_prev                   = '0;
        page_ref                    = '0;
        page_switch                 = 0;
        mismatch_count              = 0;
        failure_count               = 0;

        repeat (10) @(posedge master_clock);
        rst       <= 1'b0;
        checks_on <= 1'b1;
        repeat (4) @(posedge master_clock);

        load_page_image();
        run_full_shift();

        scatter_writes(64, 1'b1);
        scatter_writes(16, 1'b0);
        run_full_shift();

        repeat (5) pulse_replicator(1'b1, 1'b0);

        @(posedge master_clock);
        bootloop_enable <= 1'b1;
        repeat (4) @(posedge master_clock);
        pulse_replicator(1'b1, 1'b1);
        bootloop_enable <= 1'b0;
        repeat (4) @(posedge master_clock);

        // Runs the page field through 4095 and back to 1
        repeat (2 ** PAGE_WIDTH + 1) pulse_replicator(1'b1, 1'b0);
        repeat (4) @(posedge master_clock);

        abort_mid_page(300);
        power_loss_check();

        repeat (10) @(posedge master_clock);
        print_error_counts();
        if (mismatch_count + failure_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge master_clock);
        note_failure("run did not finish before the watchdog expired");
        print_error_counts();
        $display("tests failed");
        $finish;
    end

endmodule

//--- list.f
hdl/drive_geometry_pkg.sv
hdl/drive_timing_pkg.sv
hdl/shift_sequencer.sv
hdl/channel_buffer.sv
hdl/bubble_output_stage.sv
hdl/bubble_drive_top.sv
testbench/bubble_drive_tb.sv

//--- Makefile
TOP = bubble_drive_tb

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
